//--- Bender.yml
package:
  name: uart_tx

sources:
  - include_dirs:
      - .
    files:
      - uart_pkg.sv
      - uart_regs_pkg.sv
      - uart_reg_front.sv
      - uart_tx_fifo.sv
      - uart_tx_serializer.sv
      - uart_tx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_uart_monitor.sv
      - tb_uart_tx.sv

//--- flist.f
+incdir+.
uart_pkg.sv
uart_regs_pkg.sv
uart_reg_front.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_uart_monitor.sv
tb_uart_tx.sv

//--- tb_uart_monitor.sv
// UART line monitor for the transmit testbench
// Decodes frames on the line and compares them with the bytes written
// Holds the ready, interrupt and line checks used by the test sequence

`timescale 1ns/100ps

`include "uart_cfg.svh"

module tb_uart_monitor
(
    input logic i_clk,
    input logic i_arst_n,
    input logic i_txd,
    input logic i_wr_ready,
    input logic i_tx_int
);

    localparam int BIT_CLKS  = `UART_CLKS_PER_BIT;
    localparam int STOP_CLKS = `UART_STOP_BITS * `UART_CLKS_PER_BIT;

    // Bytes accepted on the write port, oldest first
    logic [7:0] expected_q [$];
    int         error_count;
    int         check_count;
    int         start_count;
    int         frame_count;
    logic       prev_txd;

    // ====================
    // Check helpers
    // ====================

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0d ns: %s, expected %0h, got %0h", $time, what, exp, got);
        end
    endtask

    task automatic push_expected(input logic [7:0] value);
        expected_q.push_back(value);
    endtask

    task automatic check_ready(input logic exp, input string what);
        compare(what, i_wr_ready, exp);
    endtask

    task automatic check_int(input logic exp, input string what);
        compare(what, i_tx_int, exp);
    endtask

    task automatic check_line_idle(input string what);
        compare(what, i_txd, 1'b1);
    endtask

    task automatic check_starts(input int exp, input string what);
        compare(what, start_count, exp);
    endtask

    // Nothing accepted may be left behind
    task automatic check_drained();
        compare("bytes still waiting for the line", expected_q.size(), 0);
    endtask

    // ====================
    // Frame decoder
    // ====================

    // Entered on the first low sample of a start bit
    task automatic decode_frame();
        int         i;
        logic [7:0] data;
        logic       stop_ok;
        start_count++;
        // Middle of the start bit
        repeat (BIT_CLKS / 2) @(negedge i_clk);
        compare("start bit low at mid bit", i_txd, 1'b0);
        // Data bits LSB first, one bit time apart
        for (i = 0; i < 8; i++)
        begin
            repeat (BIT_CLKS) @(negedge i_clk);
            data[i] = i_txd;
        end
        // Up to the last sample before the stop period
        repeat (BIT_CLKS - BIT_CLKS / 2 - 1) @(negedge i_clk);
        stop_ok = 1'b1;
        // Every clock of the stop period must be high
        for (i = 0; i < STOP_CLKS; i++)
        begin
            @(negedge i_clk);
            if (i_txd !== 1'b1)
            begin
                stop_ok = 1'b0;
            end
        end
        frame_count++;
        compare("stop period high", stop_ok, 1'b1);
        if (expected_q.size() == 0)
        begin
            check_count++;
            error_count++;
            $display("Byte %0h appeared on the line with no write waiting for it", data);
        end
        else
        begin
            compare($sformatf("line byte %0d", frame_count), data, expected_q.pop_front());
        end
    endtask

    // Line watch on the falling clock edge where txd is stable
    initial
    begin
        error_count = 0;
        check_count = 0;
        start_count = 0;
        frame_count = 0;
        prev_txd    = 1'b1;
        forever
        begin
            @(negedge i_clk);
            if (i_arst_n && prev_txd === 1'b1 && i_txd === 1'b0)
            begin
                decode_frame();
            end
            prev_txd = i_txd;
        end
    end

endmodule

//--- tb_uart_tx.sv
// UART transmitter testbench top
// Drives register writes from the pattern file and gates the line with clear-to-send
// Frame decoding and comparisons sit in the monitor

`timescale 1ns/100ps

`include "uart_cfg.svh"

module tb_uart_tx;

    localparam int NUM_PATTERNS   = 22;
    localparam int FIFO_FILL      = `UART_FIFO_DEPTH;
    localparam int FRAME_CLKS     = (10 + `UART_STOP_BITS) * `UART_CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = NUM_PATTERNS * FRAME_CLKS + 2000;

    logic                     clk;
    logic                     arst_n;
    logic                     wr_valid;
    logic                     wr_ready;
    uart_regs_pkg::reg_addr_t wr_addr;
    uart_pkg::byte_t          wr_data;
    logic                     cts_n;
    logic                     txd;
    logic                     tx_int;

    logic [7:0] patterns [NUM_PATTERNS];
    integer     seed;
    int         cycle_count;
    int         run_errors;
    int         tests_passed;
    int         tests_failed;
    int         errors_at_start;

    uart_tx_top DUT
    (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_wr_valid (wr_valid),
        .o_wr_ready (wr_ready),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .i_cts_n    (cts_n),
        .o_txd      (txd),
        .o_tx_int   (tx_int)
    );

    tb_uart_monitor u_monitor
    (
        .i_clk      (clk),
        .i_arst_n   (arst_n),
        .i_txd      (txd),
        .i_wr_ready (wr_ready),
        .i_tx_int   (tx_int)
    );

    // 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================
    // Run control
    // ====================

    task automatic end_run();
        int total_errors;
        total_errors = u_monitor.error_count + run_errors;
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, u_monitor.check_count, total_errors);
        if (total_errors == 0 && tests_failed == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic start_test();
        errors_at_start = u_monitor.error_count;
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        errs = u_monitor.error_count - errors_at_start;
        if (errs == 0)
        begin
            tests_passed++;
            $display("Test %0d %s: pass", num, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: fail with %0d errors", num, name, errs);
        end
    endtask

    // Watchdog sized from the number of frames
    initial
    begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles because the tests did not finish",
                 cycle_count);
        run_errors++;
        end_run();
    end

    // ====================
    // Write port
    // ====================

    // Hold the write until the accepting edge
    // Ready is sampled after the falling edge where it is settled
    task automatic wait_accept();
        logic accepted;
        accepted = 1'b0;
        while (!accepted)
        begin
            #2;
            accepted = wr_ready;
            @(negedge clk);
        end
        wr_valid = 1'b0;
        if (wr_addr == uart_regs_pkg::REG_DR)
        begin
            u_monitor.push_expected(wr_data);
        end
    endtask

    // Called on a falling edge
    task automatic do_write(input uart_regs_pkg::reg_addr_t addr, input uart_pkg::byte_t data);
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        wait_accept();
    endtask

    // ====================
    // Test sequence
    // ====================

    task automatic run_tests();
        uart_regs_pkg::cr_t cr;
        int                 idx;
        int                 gap;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Quiet line and interrupt with no writes
        start_test();
        repeat (20)
        begin
            @(negedge clk);
            u_monitor.check_line_idle("line high after reset");
            u_monitor.check_int(1'b0, "interrupt low after reset");
        end
        report_test(1, "reset state");

        // Enable bit only, FIFO empty
        start_test();
        cr           = '0;
        cr.tx_int_en = 1'b1;
        do_write(uart_regs_pkg::REG_CR, cr);
        @(negedge clk);
        u_monitor.check_int(1'b1, "interrupt high with empty FIFO");
        report_test(2, "interrupt enable");

        // Fill the FIFO while the line is held off
        start_test();
        for (idx = 0; idx < FIFO_FILL; idx++)
        begin
            do_write(uart_regs_pkg::REG_DR, patterns[idx]);
            if (idx == `UART_INT_LEVEL - 1)
            begin
                @(negedge clk);
                u_monitor.check_int(1'b1, "interrupt high at the level");
            end
            if (idx == `UART_INT_LEVEL)
            begin
                @(negedge clk);
                u_monitor.check_int(1'b0, "interrupt low above the level");
            end
        end
        // One write past full stays pending
        wr_valid = 1'b1;
        wr_addr  = uart_regs_pkg::REG_DR;
        wr_data  = patterns[FIFO_FILL];
        repeat (4)
        begin
            #2;
            u_monitor.check_ready(1'b0, "ready low on a full FIFO");
            u_monitor.check_line_idle("line high while clear-to-send is off");
            @(negedge clk);
        end
        u_monitor.check_starts(0, "frames started while clear-to-send is off");
        report_test(3, "FIFO fill with clear-to-send off");

        // Release the line
        // Every frame start pops one byte
        start_test();
        cts_n = 1'b0;
        wait_accept();
        while (tx_int !== 1'b1)
        begin
            @(negedge clk);
        end
        u_monitor.check_starts(FIFO_FILL + 1 - `UART_INT_LEVEL,
                               "frames started when the interrupt returned");
        report_test(4, "interrupt return while draining");

        // Remaining bytes with random idle gaps
        start_test();
        for (idx = FIFO_FILL + 1; idx < NUM_PATTERNS; idx++)
        begin
            gap = $random(seed) & 255;
            repeat (gap) @(negedge clk);
            do_write(uart_regs_pkg::REG_DR, patterns[idx]);
        end
        while (u_monitor.frame_count < NUM_PATTERNS)
        begin
            @(negedge clk);
        end
        // Quiet spell to catch a repeated frame
        repeat (FRAME_CLKS) @(negedge clk);
        u_monitor.check_starts(NUM_PATTERNS, "total frames on the line");
        u_monitor.check_drained();
        report_test(5, "random gap writes and line order");
    endtask

    initial
    begin : stimulus
        int idx;
        seed         = 12480;
        run_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        wr_valid     = 1'b0;
        wr_addr      = uart_regs_pkg::REG_DR;
        wr_data      = '0;
        cts_n        = 1'b1;
        for (idx = 0; idx < NUM_PATTERNS; idx++)
        begin
            patterns[idx] = 'x;
        end
        $readmemh("tx_patterns.hex", patterns);
        for (idx = 0; idx < NUM_PATTERNS; idx++)
        begin
            if ($isunknown(patterns[idx]))
            begin
                run_errors++;
            end
        end
        if (run_errors != 0)
        begin
            $display("Pattern file tx_patterns.hex is missing or holds fewer than %0d bytes",
                     NUM_PATTERNS);
        end
        else
        begin
            run_tests();
        end
        end_run();
    end

endmodule

//--- tx_patterns.hex
// Each line holds one byte written to REG_DR
// The same bytes are expected on o_txd in this order
00
FF
55
AA
01
80
3C
C3
0F
F0
12
34
56
78
9A
BC
DE
7E
81
A5
5A
E7

//--- uart_cfg.svh
// UART transmitter build-time configuration
// Bit timing, stop period, FIFO size and interrupt level
// All values fixed before synthesis

`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// ====================
// Bit timing
// ====================

// System clocks per bit time
// 16 keeps simulation short
`define UART_CLKS_PER_BIT 16

// Whole bit times in the stop period
`define UART_STOP_BITS 2

// ====================
// Transmit FIFO
// ====================

// Flip-flop entries in the transmit FIFO
`define UART_FIFO_DEPTH 16

// Transmit interrupt may fire at or below this count
// Half the FIFO depth
`define UART_INT_LEVEL 8

`endif

//--- uart_pkg.sv
// UART transmit datapath types
// Character, FIFO occupancy and serializer state

`include "uart_cfg.svh"

package uart_pkg;

    // ====================
    // Payload
    // ====================

    // One character on the line
    typedef logic [7:0] byte_t;

    // ====================
    // FIFO bookkeeping
    // ====================

    // Entry count
    // Needs one extra code so that a full FIFO is representable
    typedef logic [$clog2(`UART_FIFO_DEPTH + 1) - 1:0] fifo_count_t;

    // ====================
    // Serializer
    // ====================

    // Frame sequencing
    // Idle line, start bit, eight data bits, stop period
    typedef enum logic [1:0]
    {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

endpackage

//--- uart_reg_front.sv
// UART register front end
// Decodes byte writes into FIFO pushes and the control register
// Registers the transmit interrupt from enable and FIFO level

`timescale 1ns/100ps

module uart_reg_front
(
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_wr_valid,
    input  uart_regs_pkg::reg_addr_t i_wr_addr,
    input  uart_pkg::byte_t          i_wr_data,
    input  logic                     i_push_ready,
    input  logic                     i_at_or_below_level,
    output logic                     o_wr_ready,
    output logic                     o_push_valid,
    output uart_pkg::byte_t          o_push_data,
    output logic                     o_tx_int
);

    uart_regs_pkg::cr_t cr_q;
    logic               sel_dr;
    logic               sel_cr;

    // ====================
    // Address decode
    // ====================

    assign sel_dr = (i_wr_addr == uart_regs_pkg::REG_DR);
    assign sel_cr = (i_wr_addr == uart_regs_pkg::REG_CR);

    // Data writes stall on a full FIFO
    // Everything else is accepted at once
    assign o_wr_ready = sel_dr ? i_push_ready : 1'b1;

    // Push link
    // Valid comes only from the write side
    assign o_push_valid = i_wr_valid && sel_dr;
    assign o_push_data  = i_wr_data;

    // ====================
    // Control register
    // ====================

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            cr_q <= '0;
        end
        else if (i_wr_valid && sel_cr)
        begin
            cr_q <= uart_regs_pkg::cr_t'(i_wr_data);
        end
    end

    // Transmit interrupt
    // Level based, drops by itself as the FIFO fills
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_tx_int <= 1'b0;
        end
        else
        begin
            o_tx_int <= cr_q.tx_int_en && i_at_or_below_level;
        end
    end

endmodule

//--- uart_regs_pkg.sv
// UART transmit register map
// Write-only data and control registers

package uart_regs_pkg;

    // Register addresses
    typedef enum logic [1:0]
    {
        // Transmit data, one byte per write
        REG_DR = 2'd0,
        // Control
        REG_CR = 2'd1
    } reg_addr_t;

    // Control register layout
    // Transmit interrupt enable sits at bit 5
    typedef struct packed
    {
        logic [1:0] rsvd_hi;
        logic       tx_int_en;
        logic [4:0] rsvd_lo;
    } cr_t;

endpackage

//--- uart_tx_fifo.sv
// UART transmit FIFO
// Circular buffer of flip-flop byte entries
// Simultaneous push and pop, count based full, empty and level flags

`timescale 1ns/100ps

`include "uart_cfg.svh"

module uart_tx_fifo
(
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_push_valid,
    input  uart_pkg::byte_t i_push_data,
    input  logic            i_pop_ready,
    output logic            o_push_ready,
    output logic            o_pop_valid,
    output uart_pkg::byte_t o_pop_data,
    output logic            o_at_or_below_level
);

    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

    uart_pkg::byte_t       mem [`UART_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    uart_pkg::fifo_count_t count;
    logic                  push;
    logic                  pop;

    // Advance a pointer with wrap at the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`UART_FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ====================
    // Flags
    // ====================

    assign o_push_ready        = (count != uart_pkg::fifo_count_t'(`UART_FIFO_DEPTH));
    assign o_pop_valid         = (count != '0);
    assign o_at_or_below_level = (count <= uart_pkg::fifo_count_t'(`UART_INT_LEVEL));

    assign push = i_push_valid && o_push_ready;
    assign pop  = o_pop_valid && i_pop_ready;

    // Head entry
    assign o_pop_data = mem[rd_ptr];

    // ====================
    // Storage
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Count holds when both or neither happen
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- uart_tx_serializer.sv
// UART transmit serializer
// Synchronises clear-to-send, times bits from the system clock
// Sends start bit, eight data bits LSB first, then the stop period

`timescale 1ns/100ps

`include "uart_cfg.svh"

module uart_tx_serializer
(
    input  logic            i_clk,
    input  logic            i_arst_n,
    input  logic            i_cts_n,
    input  logic            i_pop_valid,
    input  uart_pkg::byte_t i_pop_data,
    output logic            o_pop_ready,
    output logic            o_txd
);

    localparam int STOP_CLKS = `UART_STOP_BITS * `UART_CLKS_PER_BIT;
    // Sized for the longest timed period, the stop period
    localparam int CNT_W     = $clog2(STOP_CLKS + 1);

    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] STOP_LAST = CNT_W'(STOP_CLKS - 1);

    logic [2:0]          cts_sync;
    logic                cts_ok;
    uart_pkg::tx_state_t state;
    logic [CNT_W-1:0]    clk_cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shift_q;
    logic                bit_end;

    // ====================
    // Clear-to-send
    // ====================

    // Three flops against metastability, idles deasserted
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            cts_sync <= 3'b111;
        end
        else
        begin
            cts_sync <= {cts_sync[1:0], i_cts_n};
        end
    end

    assign cts_ok = ~cts_sync[2];

    // Take a byte only from idle with the line cleared
    assign o_pop_ready = (state == uart_pkg::TX_IDLE) && cts_ok;

    // Last clock of a start or data bit
    assign bit_end = (clk_cnt == BIT_LAST);

    // ====================
    // Frame FSM
    // ====================

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state   <= uart_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end
        else
        begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                uart_pkg::TX_IDLE:
                begin
                    clk_cnt <= '0;
                    o_txd   <= 1'b1;
                    // Start bit on the line from the next cycle
                    if (o_pop_ready && i_pop_valid)
                    begin
                        state <= uart_pkg::TX_START;
                        o_txd <= 1'b0;
                    end
                end
                uart_pkg::TX_START:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= uart_pkg::TX_DATA;
                        o_txd   <= shift_q[0];
                    end
                end
                uart_pkg::TX_DATA:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        // Next bit sits one above the one now on the line
                        o_txd   <= shift_q[1];
                        if (bit_idx == 3'd7)
                        begin
                            state <= uart_pkg::TX_STOP;
                            o_txd <= 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP:
                begin
                    o_txd <= 1'b1;
                    if (clk_cnt == STOP_LAST)
                    begin
                        clk_cnt <= '0;
                        state   <= uart_pkg::TX_IDLE;
                    end
                end
                default:
                begin
                    state <= uart_pkg::TX_IDLE;
                    o_txd <= 1'b1;
                end
            endcase
        end
    end

    // Shift register
    // Loaded on pop, moves right after each data bit
    always_ff @(posedge i_clk)
    begin
        if (o_pop_ready && i_pop_valid)
        begin
            shift_q <= i_pop_data;
        end
        else if (state == uart_pkg::TX_DATA && bit_end)
        begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

//--- uart_tx_top.sv
// UART transmitter top level
// Register front end feeds the FIFO, serializer drains it onto the line

`timescale 1ns/100ps

module uart_tx_top
(
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    // Write port
    input  logic                     i_wr_valid,
    output logic                     o_wr_ready,
    input  uart_regs_pkg::reg_addr_t i_wr_addr,
    input  uart_pkg::byte_t          i_wr_data,
    // Line side
    input  logic                     i_cts_n,
    output logic                     o_txd,
    output logic                     o_tx_int
);

    // Front end to FIFO
    logic            push_valid;
    logic            push_ready;
    uart_pkg::byte_t push_data;
    logic            at_or_below_level;

    // FIFO to serializer
    logic            pop_valid;
    logic            pop_ready;
    uart_pkg::byte_t pop_data;

    uart_reg_front u_reg_front
    (
        .i_clk               (i_clk),
        .i_arst_n            (i_arst_n),
        .i_wr_valid          (i_wr_valid),
        .i_wr_addr           (i_wr_addr),
        .i_wr_data           (i_wr_data),
        .i_push_ready        (push_ready),
        .i_at_or_below_level (at_or_below_level),
        .o_wr_ready          (o_wr_ready),
        .o_push_valid        (push_valid),
        .o_push_data         (push_data),
        .o_tx_int            (o_tx_int)
    );

    uart_tx_fifo u_tx_fifo
    (
        .i_clk               (i_clk),
        .i_arst_n            (i_arst_n),
        .i_push_valid        (push_valid),
        .i_push_data         (push_data),
        .i_pop_ready         (pop_ready),
        .o_push_ready        (push_ready),
        .o_pop_valid         (pop_valid),
        .o_pop_data          (pop_data),
        .o_at_or_below_level (at_or_below_level)
    );

    uart_tx_serializer u_tx_serializer
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_cts_n     (i_cts_n),
        .i_pop_valid (pop_valid),
        .i_pop_data  (pop_data),
        .o_pop_ready (pop_ready),
        .o_txd       (o_txd)
    );

endmodule
